/* Bender.yml */
package:
  name: ctu_sync

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/ctu_clk_pkg.sv
      - design/ctu_sync_pkg.sv
      - design/clk_sync_ctl.sv
      - design/sync_pulse_gen.sv
      - design/sync_delay_line.sv
      - design/sync_pulse_filter.sv
      - design/ctu_sync_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - test/ctu_sync_tb.sv

/* design/clk_sync_ctl.sv */
`timescale 1ns/1ps

`include "ctu_sync_cfg.svh"

module clk_sync_ctl (
   input  logic cmp_clk,     // Core clock
   input  logic rst_n,       // Sync reset
   input  logic start_clk,   // Clock start level
   output logic ratio_load,  // Latch ratios into generator
   output logic gen_run,     // Generator counting
   output logic filter_rel   // Start-up filter released
);

   import ctu_clk_pkg::*;

   localparam int SETTLE_W = $clog2(`CTU_SETTLE_CYCLES + 1);  // Room for the full count
   localparam int SETTLE_LAST = `CTU_SETTLE_CYCLES - 1;       // Last settle count

   ctl_state_e state;                // Current state
   ctl_state_e state_nxt;            // Next state
   logic start_q;                    // start_clk one cycle back
   logic start_rise;                 // Rising edge of start_clk
   logic [SETTLE_W-1:0] settle_cnt;  // Cycles spent in settle
   logic settle_done;                // Final settle cycle

   assign start_rise = start_clk & ~start_q;
   assign settle_done = (settle_cnt == SETTLE_W'(SETTLE_LAST));

   always_comb begin
      state_nxt = state;  // Hold by default
      if (!start_clk) begin
         state_nxt = st_idle;  // Stop from anywhere
      end else begin
         case (state)
            st_idle: begin
               if (start_rise) begin
                  state_nxt = st_load;  // Fresh start only
               end
            end
            st_load: begin
               state_nxt = st_settle;  // Single load cycle
            end
            st_settle: begin
               if (settle_done) begin
                  state_nxt = st_run;
               end
            end
            st_run: begin
               state_nxt = st_run;  // Until start_clk drops
            end
            default: begin
               state_nxt = st_idle;
            end
         endcase
      end
   end

   always_ff @(posedge cmp_clk) begin
      if (!rst_n) begin
         state      <= st_idle;
         start_q    <= 1'b0;
         settle_cnt <= '0;
      end else begin
         state   <= state_nxt;
         start_q <= start_clk;  // Edge detect history
         if (state == st_settle) begin
            settle_cnt <= settle_cnt + 1'b1;  // Count settle cycles
         end else begin
            settle_cnt <= '0;  // Ready for next entry
         end
      end
   end

   // Outputs straight from state
   assign ratio_load = (state == st_load);
   assign gen_run    = (state == st_run);
   assign filter_rel = (state == st_run);  // Filter opens with the generator

   // Counting starts one load cycle plus the settle time after the ratio strobe
   a_load_before_run: assert property (@(posedge cmp_clk) disable iff (!rst_n)
      $rose(gen_run) |-> $past(ratio_load, `CTU_SETTLE_CYCLES + 1));

   // Release only follows a cycle with clocks started
   a_rel_after_start: assert property (@(posedge cmp_clk) disable iff (!rst_n)
      filter_rel |-> $past(start_clk));

endmodule

/* design/ctu_clk_pkg.sv */
package ctu_clk_pkg;

   // Slow domain ratio code
   // Each code gives cmp_clk cycles per slow-domain cycle
   typedef enum logic [1:0] {
      ratio_2 = 2'd0,  // 2 cmp cycles
      ratio_4 = 2'd1,  // 4 cmp cycles
      ratio_6 = 2'd2,  // 6 cmp cycles
      ratio_8 = 2'd3   // 8 cmp cycles
   } ratio_e;

   // Sync control sequence
   //   idle    waiting for start_clk to rise
   //   load    ratios latched into the generator
   //   settle  fixed wait before pulses start
   //   run     generator and filter released
   typedef enum logic [1:0] {
      st_idle   = 2'd0,  // Clocks stopped
      st_load   = 2'd1,  // One cycle ratio strobe
      st_settle = 2'd2,  // Counting settle cycles
      st_run    = 2'd3   // Pulses flowing
   } ctl_state_e;

   // Any state other than run keeps the pulse path quiet
   // Dropping start_clk always falls back to idle

   // Ratio codes are sampled only in load
   // A code change during run waits for the next start

endpackage

/* design/ctu_sync_cfg.svh */
`ifndef CTU_SYNC_CFG_SVH
`define CTU_SYNC_CFG_SVH

// Distribution depth of the jbus sync pulses in cmp_clk flops
`define CTU_JBUS_SYNC_DLY 3

// Distribution depth of the dram sync pulse in cmp_clk flops
`define CTU_DRAM_SYNC_DLY 2

// Cycles spent in settle between ratio load and run
`define CTU_SETTLE_CYCLES 4

// Width of the start-up pulse counter
// The filter opens once this counter saturates at all ones
`define CTU_FILTER_BITS 3

// Resulting start-up latency seen at the outputs
//   flag sets 2**CTU_FILTER_BITS cycles after release
//   first output pulse one cycle later at the earliest

// Raw pulse to output latency per path
//   jbus  CTU_JBUS_SYNC_DLY + 1
//   dram  CTU_DRAM_SYNC_DLY + 1

`endif

/* design/ctu_sync_pkg.sv */
package ctu_sync_pkg;

   // Number of sync paths carried through the section
   localparam int SYNC_PATHS = 3;

   // Bit position of each path in the pulse vector
   typedef enum logic [1:0] {
      path_jbus_tx = 2'd0,  // jbus transmit
      path_jbus_rx = 2'd1,  // jbus receive
      path_dram_tx = 2'd2   // dram transmit
   } sync_path_e;

   // One bit per sync path
   // Index with sync_path_e values
   typedef logic [SYNC_PATHS-1:0] sync_vec_t;

   // jbus receive trails jbus transmit by one cycle in steady state
   // dram receive is not carried

   // Both jbus bits share one distribution depth
   // The dram bit has its own shorter depth

   // Pulses are single cycle and never stalled
   // Only the start-up filter may drop them

   // Vector travels as a packed value between blocks
   // Each delay line carries one bit of it

endpackage

/* design/ctu_sync_top.sv */
`timescale 1ns/1ps

`include "ctu_sync_cfg.svh"

module ctu_sync_top (
   input  logic                cmp_clk,             // Core clock
   input  logic                rst_n,               // Sync reset
   input  logic                start_clk,           // Clock start level
   input  ctu_clk_pkg::ratio_e jbus_ratio,          // jbus ratio code
   input  ctu_clk_pkg::ratio_e dram_ratio,          // dram ratio code
   output logic                jbus_tx_sync,        // jbus transmit sync
   output logic                jbus_rx_sync,        // jbus receive sync
   output logic                dram_tx_sync_early,  // dram transmit sync
   output logic                sync_active          // Generator running
);

   import ctu_sync_pkg::*;

   logic      ratio_load;  // Ratio latch strobe
   logic      gen_run;     // Generator enable
   logic      filter_rel;  // Filter release
   sync_vec_t raw_sync;    // Pulses at the source
   sync_vec_t dly_sync;    // Pulses after distribution

   clk_sync_ctl clk_sync_ctl_i (
      .cmp_clk    (cmp_clk),
      .rst_n      (rst_n),
      .start_clk  (start_clk),
      .ratio_load (ratio_load),
      .gen_run    (gen_run),
      .filter_rel (filter_rel)
   );

   sync_pulse_gen sync_pulse_gen_i (
      .cmp_clk    (cmp_clk),
      .rst_n      (rst_n),
      .ratio_load (ratio_load),
      .gen_run    (gen_run),
      .jbus_ratio (jbus_ratio),
      .dram_ratio (dram_ratio),
      .raw_sync   (raw_sync)
   );

   sync_delay_line #(.DEPTH(`CTU_JBUS_SYNC_DLY)) jbus_tx_dly_i (
      .cmp_clk (cmp_clk),
      .rst_n   (rst_n),
      .din     (raw_sync[path_jbus_tx]),
      .dout    (dly_sync[path_jbus_tx])
   );

   sync_delay_line #(.DEPTH(`CTU_JBUS_SYNC_DLY)) jbus_rx_dly_i (
      .cmp_clk (cmp_clk),
      .rst_n   (rst_n),
      .din     (raw_sync[path_jbus_rx]),
      .dout    (dly_sync[path_jbus_rx])
   );

   sync_delay_line #(.DEPTH(`CTU_DRAM_SYNC_DLY)) dram_tx_dly_i (
      .cmp_clk (cmp_clk),
      .rst_n   (rst_n),
      .din     (raw_sync[path_dram_tx]),
      .dout    (dly_sync[path_dram_tx])
   );

   sync_pulse_filter sync_pulse_filter_i (
      .cmp_clk            (cmp_clk),
      .rst_n              (rst_n),
      .filter_rel         (filter_rel),
      .dly_sync           (dly_sync),
      .jbus_tx_sync       (jbus_tx_sync),
      .jbus_rx_sync       (jbus_rx_sync),
      .dram_tx_sync_early (dram_tx_sync_early)
   );

   assign sync_active = gen_run;  // Visible run status

endmodule

/* design/sync_delay_line.sv */
`timescale 1ns/1ps

module sync_delay_line #(
   parameter int DEPTH = 2  // Flops in the chain
) (
   input  logic cmp_clk,  // Core clock
   input  logic rst_n,    // Sync reset
   input  logic din,      // Pulse at the source
   output logic dout      // Pulse at the far end
);

   logic [DEPTH-1:0] stage;  // One flop per distribution hop

   // A chain needs at least one flop
   if (DEPTH < 1) begin : g_depth_check
      $error("sync_delay_line DEPTH must be at least 1");
   end

   always_ff @(posedge cmp_clk) begin
      if (!rst_n) begin
         stage <= '0;  // Chain empty after reset
      end else begin
         stage[0] <= din;  // First hop
         for (int i = 1; i < DEPTH; i++) begin
            stage[i] <= stage[i-1];  // Shift along the path
         end
      end
   end

   // Last hop drives the local copy
   assign dout = stage[DEPTH-1];

   // A pulse entering now leaves DEPTH cycles later
   // Pulse width is kept since every hop is one flop
   // No gating along the way

   // Depth is set per path at the top level
   // jbus paths run longer than the dram path

   // Short chains model a nearby cluster
   // Long chains model the far edge of the die

endmodule

/* design/sync_pulse_filter.sv */
`timescale 1ns/1ps

`include "ctu_sync_cfg.svh"

module sync_pulse_filter (
   input  logic                    cmp_clk,            // Core clock
   input  logic                    rst_n,              // Sync reset
   input  logic                    filter_rel,         // Release from control
   input  ctu_sync_pkg::sync_vec_t dly_sync,           // Pulses after distribution
   output logic                    jbus_tx_sync,       // Filtered jbus transmit
   output logic                    jbus_rx_sync,       // Filtered jbus receive
   output logic                    dram_tx_sync_early  // Filtered dram transmit
);

   import ctu_sync_pkg::*;

   localparam int CNT_W = `CTU_FILTER_BITS;  // Start-up counter width

   logic [CNT_W-1:0] pulse_cnt;   // Cycles since release
   logic pulse_cnt_dn;            // Counter saturated
   logic pulse_filter;            // Pulses allowed through
   logic jbus_tx_sync_nxt;        // Gated jbus transmit
   logic jbus_rx_sync_nxt;        // Gated jbus receive
   logic dram_tx_sync_early_nxt;  // Gated dram transmit

   // Saturation at all ones
   assign pulse_cnt_dn = &pulse_cnt;

   always_ff @(posedge cmp_clk) begin
      if (!rst_n || !filter_rel) begin
         pulse_cnt    <= '0;    // Restart on every release
         pulse_filter <= 1'b0;  // Closed until counter runs out
      end else begin
         if (!pulse_cnt_dn) begin
            pulse_cnt <= pulse_cnt + 1'b1;
         end
         pulse_filter <= pulse_cnt_dn;  // Opens one cycle after saturation
      end
   end

   // Early pulses from a settling distribution are dropped here
   assign jbus_tx_sync_nxt       = dly_sync[path_jbus_tx] & pulse_filter;
   assign jbus_rx_sync_nxt       = dly_sync[path_jbus_rx] & pulse_filter;
   assign dram_tx_sync_early_nxt = dly_sync[path_dram_tx] & pulse_filter;

   always_ff @(posedge cmp_clk) begin
      if (!rst_n) begin
         jbus_tx_sync       <= 1'b0;
         jbus_rx_sync       <= 1'b0;
         dram_tx_sync_early <= 1'b0;
      end else begin
         jbus_tx_sync       <= jbus_tx_sync_nxt;  // Final retime to cmp_clk
         jbus_rx_sync       <= jbus_rx_sync_nxt;
         dram_tx_sync_early <= dram_tx_sync_early_nxt;
      end
   end

   // Nothing leaves before release has run the full start-up count
   a_out_after_flag: assert property (@(posedge cmp_clk) disable iff (!rst_n)
      (jbus_tx_sync || jbus_rx_sync || dram_tx_sync_early) |->
         $past(filter_rel, 2**CNT_W + 1));

   // Flag sets 2**CNT_W cycles after release
   // First pulse at the outputs one cycle after that

   // Dropping the release clears counter and flag together
   // Outputs fall silent on the following cycle

endmodule

/* design/sync_pulse_gen.sv */
`timescale 1ns/1ps

module sync_pulse_gen (
   input  logic                   cmp_clk,     // Core clock
   input  logic                   rst_n,       // Sync reset
   input  logic                   ratio_load,  // Latch strobe from control
   input  logic                   gen_run,     // Count enable
   input  ctu_clk_pkg::ratio_e    jbus_ratio,  // jbus ratio code
   input  ctu_clk_pkg::ratio_e    dram_ratio,  // dram ratio code
   output ctu_sync_pkg::sync_vec_t raw_sync    // Raw pulses one per path
);

   import ctu_clk_pkg::*;
   import ctu_sync_pkg::*;

   localparam int CNT_W = 3;  // Enough for ratio 8

   ratio_e jbus_ratio_q;     // Latched jbus code
   ratio_e dram_ratio_q;     // Latched dram code
   logic [CNT_W-1:0] jbus_cnt;   // jbus phase counter
   logic [CNT_W-1:0] dram_cnt;   // dram phase counter
   logic [CNT_W-1:0] jbus_last;  // jbus wrap point
   logic [CNT_W-1:0] dram_last;  // dram wrap point

   // Ratio code to cmp_clk cycles per slow cycle
   function automatic logic [CNT_W:0] ratio_cycles(input ratio_e code);
      case (code)
         ratio_2: ratio_cycles = 4'd2;
         ratio_4: ratio_cycles = 4'd4;
         ratio_6: ratio_cycles = 4'd6;
         ratio_8: ratio_cycles = 4'd8;
         default: ratio_cycles = 4'd2;
      endcase
   endfunction

   assign jbus_last = CNT_W'(ratio_cycles(jbus_ratio_q) - 1'b1);
   assign dram_last = CNT_W'(ratio_cycles(dram_ratio_q) - 1'b1);

   always_ff @(posedge cmp_clk) begin
      if (!rst_n) begin
         jbus_ratio_q <= ratio_2;
         dram_ratio_q <= ratio_2;
      end else if (ratio_load) begin
         jbus_ratio_q <= jbus_ratio;  // Sampled once per start
         dram_ratio_q <= dram_ratio;
      end
   end

   always_ff @(posedge cmp_clk) begin
      if (!rst_n || !gen_run) begin
         jbus_cnt <= '0;  // Parked at phase 0
         dram_cnt <= '0;
      end else begin
         jbus_cnt <= (jbus_cnt == jbus_last) ? '0 : jbus_cnt + 1'b1;
         dram_cnt <= (dram_cnt == dram_last) ? '0 : dram_cnt + 1'b1;
      end
   end

   always_ff @(posedge cmp_clk) begin
      if (!rst_n) begin
         raw_sync <= '0;
      end else begin
         raw_sync[path_jbus_tx] <= gen_run && (jbus_cnt == jbus_last);  // End of jbus cycle
         raw_sync[path_jbus_rx] <= gen_run && (jbus_cnt == '0);         // Start of jbus cycle
         raw_sync[path_dram_tx] <= gen_run && (dram_cnt == dram_last);  // End of dram cycle
      end
   end

   // Transmit and receive mark different jbus phases
   a_tx_rx_apart: assert property (@(posedge cmp_clk) disable iff (!rst_n)
      !(raw_sync[path_jbus_tx] && raw_sync[path_jbus_rx]));

endmodule

/* filelist.f */
+incdir+design
design/ctu_clk_pkg.sv
design/ctu_sync_pkg.sv
design/clk_sync_ctl.sv
design/sync_pulse_gen.sv
design/sync_delay_line.sv
design/sync_pulse_filter.sv
design/ctu_sync_top.sv
test/ctu_sync_tb.sv

/* test/ctu_sync_tb.sv */
`timescale 1ns/1ps

`include "ctu_sync_cfg.svh"

module ctu_sync_tb;

   import ctu_clk_pkg::*;
   import ctu_sync_pkg::*;

   localparam int CLK_PERIOD  = 40;                         // cmp_clk period in ns
   localparam int RUN_LAT     = 2 + `CTU_SETTLE_CYCLES;     // start_clk to sync_active
   localparam int START_CYC   = RUN_LAT + 8;                // Start-up window with no pulses
   localparam int STOP_CYC    = 8;                          // Cycles watched after a stop
   localparam int STOP_LAT    = 5;                          // Pulses gone by this cycle
   localparam int MEAS_PULSES = 4;                          // Pulses per spacing run
   localparam int MEAS_CYC    = 8 * (MEAS_PULSES + 2);      // Cycle limit per spacing run
   localparam int RESTART_CYC = STOP_CYC + START_CYC + MEAS_CYC;
   localparam int TEST_CYC    = 4 + 16 + START_CYC + 9 * RESTART_CYC + MEAS_CYC + 1;
   localparam int WATCHDOG_NS = 2 * TEST_CYC * CLK_PERIOD;  // Twice the expected run

   logic   cmp_clk;
   logic   rst_n;
   logic   start_clk;
   ratio_e jbus_ratio;
   ratio_e dram_ratio;
   logic   jbus_tx_sync;
   logic   jbus_rx_sync;
   logic   dram_tx_sync_early;
   logic   sync_active;

   int cycle = 0;                   // Free running cycle count
   int err_cnt = 0;                 // Failed checks
   int check_cnt = 0;               // All checks
   int test_cnt = 0;                // Finished tests
   logic [7:0] lfsr_state = 8'd90;  // Stimulus LFSR

   ctu_sync_top dut_i (
      .cmp_clk            (cmp_clk),
      .rst_n              (rst_n),
      .start_clk          (start_clk),
      .jbus_ratio         (jbus_ratio),
      .dram_ratio         (dram_ratio),
      .jbus_tx_sync       (jbus_tx_sync),
      .jbus_rx_sync       (jbus_rx_sync),
      .dram_tx_sync_early (dram_tx_sync_early),
      .sync_active        (sync_active)
   );

   initial cmp_clk = 1'b0;
   always #(CLK_PERIOD / 2) cmp_clk = ~cmp_clk;

   always @(posedge cmp_clk) begin
      cycle <= cycle + 1;  // Read only at negedge
   end

   // Galois form, taps for x^8 + x^6 + x^5 + x^4 + 1
   function automatic logic [7:0] lfsr_next(input logic [7:0] s);
      logic [7:0] n;
      n = s >> 1;
      if (s[0]) begin
         n = n ^ 8'hB8;
      end
      return n;
   endfunction

   task automatic take_bits(input int n, output logic [7:0] val);
      val = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state);  // One step per bit
         val = {val[6:0], lfsr_state[0]};
      end
   endtask

   // Land at the negedge after the next rising edge
   task automatic step_cycle();
      @(posedge cmp_clk);
      @(negedge cmp_clk);
   endtask

   task automatic compare_bit(input logic actual, input logic expected, input string what);
      check_cnt++;
      if (actual !== expected) begin
         err_cnt++;
         $display("error %0t ns: %s is %b, expected %b", $time, what, actual, expected);
      end
   endtask

   task automatic compare_ratio(input ratio_e code, input int measured, input string what);
      int expected;
      expected = 2 * (int'(code) + 1);  // Codes step by two cycles from 2
      check_cnt++;
      if (measured != expected) begin
         err_cnt++;
         $display("error %0t ns: %s spacing %0d, expected %0d for ratio code %0d",
                  $time, what, measured, expected, int'(code));
      end
   endtask

   function automatic logic pulse_of(input sync_path_e path);
      case (path)
         path_jbus_tx: return jbus_tx_sync;
         path_jbus_rx: return jbus_rx_sync;
         default:      return dram_tx_sync_early;
      endcase
   endfunction

   task automatic check_quiet(input string where);
      compare_bit(jbus_tx_sync, 1'b0, {"jbus_tx_sync ", where});
      compare_bit(jbus_rx_sync, 1'b0, {"jbus_rx_sync ", where});
      compare_bit(dram_tx_sync_early, 1'b0, {"dram_tx_sync_early ", where});
   endtask

   task automatic stop_sync();
      @(posedge cmp_clk);
      start_clk <= 1'b0;
      for (int cyc = 1; cyc <= STOP_CYC; cyc++) begin
         step_cycle();
         compare_bit(sync_active, 1'b0, "sync_active after stop");
         if (cyc >= STOP_LAT) begin
            check_quiet("after stop");  // Tail of the pipeline has drained
         end
      end
   endtask

   task automatic start_sync(input ratio_e jr, input ratio_e dr);
      @(posedge cmp_clk);
      jbus_ratio <= jr;
      dram_ratio <= dr;
      start_clk  <= 1'b1;
      for (int cyc = 1; cyc <= START_CYC; cyc++) begin
         step_cycle();
         compare_bit(sync_active, 1'(cyc >= RUN_LAT), "sync_active after start");
         check_quiet("during start-up");  // Filter still closed
      end
   endtask

   task automatic measure_spacing(input sync_path_e path, input ratio_e code, input string what);
      int last;
      int pulses;
      int waited;
      logic seen;
      logic prev_pulse;
      logic pulse;
      last = 0;
      pulses = 0;
      waited = 0;
      seen = 1'b0;
      prev_pulse = 1'b0;
      while (pulses < MEAS_PULSES && waited < MEAS_CYC) begin
         step_cycle();
         waited++;
         pulse = pulse_of(path);
         if (path == path_jbus_tx && seen) begin
            compare_bit(jbus_rx_sync, prev_pulse, "jbus_rx_sync after jbus_tx_sync");
         end
         if (pulse) begin
            if (seen) begin
               compare_ratio(code, cycle - last, what);
            end
            last = cycle;
            seen = 1'b1;
            pulses++;
         end
         prev_pulse = pulse;
      end
      if (pulses < MEAS_PULSES) begin
         err_cnt++;
         $display("only %0d %s pulses arrived within %0d cycles", pulses, what, MEAS_CYC);
      end
   endtask

   task automatic finish_test(input string name, input int err_before);
      test_cnt++;
      if (err_cnt == err_before) begin
         $display("test %s: ok", name);
      end else begin
         $display("test %s: %0d errors", name, err_cnt - err_before);
      end
   endtask

   task automatic test_idle_quiet();
      logic [7:0] bits;
      int err_before;
      err_before = err_cnt;
      take_bits(3, bits);
      repeat (8 + int'(bits)) begin  // LFSR hold time
         step_cycle();
         compare_bit(sync_active, 1'b0, "sync_active while idle");
         check_quiet("while idle");
      end
      finish_test("idle_quiet", err_before);
   endtask

   task automatic test_start_latency();
      logic [7:0] jb;
      logic [7:0] db;
      int err_before;
      err_before = err_cnt;
      take_bits(2, jb);
      take_bits(2, db);
      start_sync(ratio_e'(jb[1:0]), ratio_e'(db[1:0]));
      finish_test("start_latency", err_before);
   endtask

   task automatic test_jbus_spacing();
      int err_before;
      err_before = err_cnt;
      for (int code = 0; code < 4; code++) begin  // Every jbus code
         stop_sync();
         start_sync(ratio_e'(2'(code)), ratio_4);
         measure_spacing(path_jbus_tx, ratio_e'(2'(code)), "jbus_tx_sync");
      end
      finish_test("jbus_spacing", err_before);
   endtask

   task automatic test_dram_spacing();
      logic [7:0] jb;
      logic [7:0] db;
      int err_before;
      err_before = err_cnt;
      repeat (3) begin
         take_bits(2, jb);
         take_bits(2, db);
         stop_sync();
         start_sync(ratio_e'(jb[1:0]), ratio_e'(db[1:0]));
         measure_spacing(path_dram_tx, ratio_e'(db[1:0]), "dram_tx_sync_early");
      end
      finish_test("dram_spacing", err_before);
   endtask

   task automatic test_change_restart();
      logic [7:0] ab;
      ratio_e code_a;
      ratio_e code_b;
      int err_before;
      err_before = err_cnt;
      take_bits(2, ab);
      code_a = ratio_e'(ab[1:0]);
      code_b = ratio_e'(~ab[1:0]);  // Always a different code
      stop_sync();
      start_sync(code_a, ratio_2);
      measure_spacing(path_jbus_tx, code_a, "jbus_tx_sync");
      @(posedge cmp_clk);
      jbus_ratio <= code_b;  // Not sampled until the next load
      measure_spacing(path_jbus_tx, code_a, "jbus_tx_sync after ratio change");
      stop_sync();
      start_sync(code_b, ratio_2);
      measure_spacing(path_jbus_tx, code_b, "jbus_tx_sync after restart");
      finish_test("change_restart", err_before);
   endtask

   initial begin
      rst_n      = 1'b0;
      start_clk  = 1'b0;
      jbus_ratio = ratio_2;
      dram_ratio = ratio_2;
      repeat (4) @(posedge cmp_clk);
      rst_n <= 1'b1;  // Out of reset after 4 cycles
      @(negedge cmp_clk);
      test_idle_quiet();
      test_start_latency();
      test_jbus_spacing();
      test_dram_spacing();
      test_change_restart();
      $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired after %0d ns with tests still running", WATCHDOG_NS);
      $display("sim failed");
      $finish;
   end

endmodule
